//--- cache_pkg.sv
// --------------------------------------
// Widths are fixed here; at most 2 requesters and 2 banks
// --------------------------------------
`default_nettype none

package cache_pkg;

    localparam int ADDR_WIDTH = 12;
    localparam int WORD_WIDTH = 32;
    localparam int LINE_WORDS = 2;
    localparam int LINE_WIDTH = 64;
    localparam int TAG_WIDTH = 6;

    // Index widths sized for the largest configuration
    localparam int MAX_REQ_BITS = 1;
    localparam int MAX_BANK_BITS = 1;

    typedef enum logic [0:0] {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        mem_op_e               op;
        logic [WORD_WIDTH-1:0] data;
        logic [TAG_WIDTH-1:0]  tag;
    } core_req_t;

    typedef struct packed {
        logic [WORD_WIDTH-1:0] data;
        logic [TAG_WIDTH-1:0]  tag;
    } core_rsp_t;

    typedef struct packed {
        core_req_t               req;
        logic [MAX_REQ_BITS-1:0] idx;
    } bank_req_t;

    typedef struct packed {
        logic [WORD_WIDTH-1:0]   data;
        logic [TAG_WIDTH-1:0]    tag;
        logic [MAX_REQ_BITS-1:0] idx;
    } bank_rsp_t;

    // Tag carries the bank index on the shared memory port
    typedef struct packed {
        mem_op_e                  op;
        logic [ADDR_WIDTH-2:0]    line_addr;
        logic [LINE_WIDTH-1:0]    data;
        logic [LINE_WORDS-1:0]    word_en;
        logic [MAX_BANK_BITS-1:0] tag;
    } mem_req_t;

    typedef struct packed {
        logic [LINE_WIDTH-1:0]    data;
        logic [MAX_BANK_BITS-1:0] tag;
    } mem_rsp_t;

    typedef enum logic [1:0] {
        S_READY,
        S_MEM_REQ,
        S_MEM_WAIT,
        S_RESPOND
    } bank_state_e;

endpackage

`default_nettype wire

//--- req_dispatch.sv
// --------------------------------------
// Combinational; a request is accepted when its bank takes it
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module req_dispatch import cache_pkg::*; #(
    parameter int NUM_REQS  = 2,
    parameter int NUM_BANKS = 2
) (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      core_req_valid [NUM_REQS],
    input  wire core_req_t core_req [NUM_REQS],
    output logic           core_req_ready [NUM_REQS],
    output logic           bank_req_valid [NUM_BANKS],
    output bank_req_t      bank_req [NUM_BANKS],
    input  wire logic      bank_req_ready [NUM_BANKS]
);

    localparam int BANK_BITS = $clog2(NUM_BANKS);

    logic [BANK_BITS-1:0]    req_bank [NUM_REQS];
    logic [MAX_REQ_BITS-1:0] grant [NUM_BANKS];
    logic [MAX_REQ_BITS-1:0] rr_ptr [NUM_BANKS];

    // Bank bits sit just above the word select bit
    always_comb begin
        for (int r = 0; r < NUM_REQS; r++) begin
            req_bank[r] = core_req[r].addr[1 +: BANK_BITS];
        end
    end

    always_comb begin
        int cand;
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_req_valid[b] = 1'b0;
            grant[b] = '0;
            // Walk down so the requester nearest the pointer wins
            for (int k = NUM_REQS - 1; k >= 0; k--) begin
                cand = (int'(rr_ptr[b]) + k) % NUM_REQS;
                if (core_req_valid[cand] && req_bank[cand] == BANK_BITS'(b)) begin
                    bank_req_valid[b] = 1'b1;
                    grant[b] = MAX_REQ_BITS'(cand);
                end
            end
            bank_req[b].req = core_req[grant[b]];
            bank_req[b].idx = grant[b];
        end
    end

    always_comb begin
        for (int r = 0; r < NUM_REQS; r++) begin
            core_req_ready[r] = core_req_valid[r]
                && bank_req_ready[req_bank[r]]
                && grant[req_bank[r]] == MAX_REQ_BITS'(r);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                rr_ptr[b] <= '0;
            end
        end else begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (bank_req_valid[b] && bank_req_ready[b]) begin
                    rr_ptr[b] <= (grant[b] == MAX_REQ_BITS'(NUM_REQS - 1))
                        ? '0 : grant[b] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- cache_bank.sv
// --------------------------------------
// Direct mapped, two-word lines; blocks until a miss is filled
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cache_bank import cache_pkg::*; #(
    parameter int NUM_BANKS = 2,
    parameter int NUM_SETS  = 8
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  req_valid,
    input  wire bank_req_t             req,
    output logic                       req_ready,
    output logic                       mem_req_valid,
    output mem_req_t                   mem_req,
    input  wire logic                  mem_req_ready,
    input  wire logic                  mem_rsp_valid,
    input  wire logic [LINE_WIDTH-1:0] mem_rsp_data,
    output logic                       rsp_valid,
    output bank_rsp_t                  rsp,
    input  wire logic                  rsp_ready
);

    localparam int BANK_BITS = $clog2(NUM_BANKS);
    localparam int SET_BITS = $clog2(NUM_SETS);
    localparam int LTAG_BITS = ADDR_WIDTH - 1 - BANK_BITS - SET_BITS;

    bank_state_e state;

    logic [NUM_SETS-1:0]                   valid_bits;
    logic [LTAG_BITS-1:0]                  tags [NUM_SETS];
    logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] lines [NUM_SETS];

    // Request held from acceptance until the bank returns to S_READY
    bank_req_t cur;

    logic [SET_BITS-1:0]  in_set;
    logic [LTAG_BITS-1:0] in_ltag;
    logic                 in_word;
    logic                 in_hit;
    logic [SET_BITS-1:0]  cur_set;
    logic [LTAG_BITS-1:0] cur_ltag;
    logic                 cur_word;

    assign in_word = req.req.addr[0];
    assign in_set = req.req.addr[1 + BANK_BITS +: SET_BITS];
    assign in_ltag = req.req.addr[ADDR_WIDTH-1 -: LTAG_BITS];
    assign in_hit = valid_bits[in_set] && tags[in_set] == in_ltag;

    assign cur_word = cur.req.addr[0];
    assign cur_set = cur.req.addr[1 + BANK_BITS +: SET_BITS];
    assign cur_ltag = cur.req.addr[ADDR_WIDTH-1 -: LTAG_BITS];

    assign req_ready = (state == S_READY);
    assign mem_req_valid = (state == S_MEM_REQ);
    assign rsp_valid = (state == S_RESPOND);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_READY;
            valid_bits <= '0;
        end else begin
            case (state)
                S_READY: begin
                    if (req_valid) begin
                        if (req.req.op == OP_READ && in_hit) begin
                            state <= S_RESPOND;
                        end else begin
                            state <= S_MEM_REQ;
                        end
                    end
                end
                S_MEM_REQ: begin
                    if (mem_req_ready) begin
                        state <= (cur.req.op == OP_WRITE) ? S_READY : S_MEM_WAIT;
                    end
                end
                S_MEM_WAIT: begin
                    if (mem_rsp_valid) begin
                        valid_bits[cur_set] <= 1'b1;
                        state <= S_RESPOND;
                    end
                end
                S_RESPOND: begin
                    if (rsp_ready) begin
                        state <= S_READY;
                    end
                end
                default: state <= S_READY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            cur <= req;
            // Write hit updates the cached word; a write miss allocates nothing
            if (req.req.op == OP_WRITE && in_hit) begin
                lines[in_set][in_word] <= req.req.data;
            end
        end
        if (state == S_MEM_WAIT && mem_rsp_valid) begin
            lines[cur_set] <= mem_rsp_data;
            tags[cur_set] <= cur_ltag;
        end
    end

    always_comb begin
        mem_req.op = cur.req.op;
        mem_req.line_addr = cur.req.addr[ADDR_WIDTH-1:1];
        mem_req.data = {LINE_WORDS{cur.req.data}};
        // Reads fetch the whole line
        mem_req.word_en = (cur.req.op == OP_WRITE)
            ? LINE_WORDS'(1) << cur_word : '1;
        mem_req.tag = '0;
    end

    // Line store is stable while responding since the bank is blocked
    always_comb begin
        rsp.data = lines[cur_set][cur_word];
        rsp.tag = cur.req.tag;
        rsp.idx = cur.idx;
    end

endmodule

`default_nettype wire

//--- mem_arbiter.sv
// --------------------------------------
// Single memory port; responses return by bank tag, never stalled
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import cache_pkg::*; #(
    parameter int NUM_BANKS = 2
) (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           bank_mem_req_valid [NUM_BANKS],
    input  wire mem_req_t       bank_mem_req [NUM_BANKS],
    output logic                bank_mem_req_ready [NUM_BANKS],
    output logic                mem_req_valid,
    output mem_req_t            mem_req,
    input  wire logic           mem_req_ready,
    input  wire logic           mem_rsp_valid,
    input  wire mem_rsp_t       mem_rsp,
    output logic                mem_rsp_ready,
    output logic                bank_mem_rsp_valid [NUM_BANKS],
    output logic [LINE_WIDTH-1:0] bank_mem_rsp_data
);

    logic [MAX_BANK_BITS-1:0] rr_ptr;
    logic [MAX_BANK_BITS-1:0] grant;
    // Last grant kept while its request waits for the port
    logic                     held;
    logic [MAX_BANK_BITS-1:0] held_grant;

    always_comb begin
        int cand;
        mem_req_valid = 1'b0;
        grant = '0;
        for (int k = NUM_BANKS - 1; k >= 0; k--) begin
            cand = (int'(rr_ptr) + k) % NUM_BANKS;
            if (bank_mem_req_valid[cand]) begin
                mem_req_valid = 1'b1;
                grant = MAX_BANK_BITS'(cand);
            end
        end
        if (held) begin
            grant = held_grant;
        end
        mem_req = bank_mem_req[grant];
        mem_req.tag = grant;
    end

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_mem_req_ready[b] = mem_req_valid && mem_req_ready
                && grant == MAX_BANK_BITS'(b);
            bank_mem_rsp_valid[b] = mem_rsp_valid && mem_rsp.tag == MAX_BANK_BITS'(b);
        end
    end

    // Banks only have a fill pending in S_MEM_WAIT
    assign mem_rsp_ready = 1'b1;
    assign bank_mem_rsp_data = mem_rsp.data;

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr <= '0;
            held <= 1'b0;
            held_grant <= '0;
        end else begin
            held <= mem_req_valid && !mem_req_ready;
            held_grant <= grant;
            if (mem_req_valid && mem_req_ready) begin
                rr_ptr <= (grant == MAX_BANK_BITS'(NUM_BANKS - 1)) ? '0 : grant + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rsp_gather.sv
// --------------------------------------
// Combinational path; a stalled response keeps its grant
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rsp_gather import cache_pkg::*; #(
    parameter int NUM_REQS  = 2,
    parameter int NUM_BANKS = 2
) (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      bank_rsp_valid [NUM_BANKS],
    input  wire bank_rsp_t bank_rsp [NUM_BANKS],
    output logic           bank_rsp_ready [NUM_BANKS],
    output logic           core_rsp_valid [NUM_REQS],
    output core_rsp_t      core_rsp [NUM_REQS],
    input  wire logic      core_rsp_ready [NUM_REQS]
);

    logic [MAX_BANK_BITS-1:0] rr_ptr [NUM_REQS];
    logic [MAX_BANK_BITS-1:0] grant [NUM_REQS];
    // Grant kept per requester while its response waits
    logic                     held [NUM_REQS];
    logic [MAX_BANK_BITS-1:0] held_grant [NUM_REQS];

    always_comb begin
        int cand;
        for (int r = 0; r < NUM_REQS; r++) begin
            core_rsp_valid[r] = 1'b0;
            grant[r] = '0;
            for (int k = NUM_BANKS - 1; k >= 0; k--) begin
                cand = (int'(rr_ptr[r]) + k) % NUM_BANKS;
                if (bank_rsp_valid[cand] && bank_rsp[cand].idx == MAX_REQ_BITS'(r)) begin
                    core_rsp_valid[r] = 1'b1;
                    grant[r] = MAX_BANK_BITS'(cand);
                end
            end
            if (held[r]) begin
                grant[r] = held_grant[r];
            end
            core_rsp[r].data = bank_rsp[grant[r]].data;
            core_rsp[r].tag = bank_rsp[grant[r]].tag;
        end
    end

    // A bank is released only when it won its requester's port
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_rsp_ready[b] = bank_rsp_valid[b]
                && core_rsp_ready[bank_rsp[b].idx]
                && grant[bank_rsp[b].idx] == MAX_BANK_BITS'(b);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < NUM_REQS; r++) begin
                rr_ptr[r] <= '0;
                held[r] <= 1'b0;
                held_grant[r] <= '0;
            end
        end else begin
            for (int r = 0; r < NUM_REQS; r++) begin
                held[r] <= core_rsp_valid[r] && !core_rsp_ready[r];
                held_grant[r] <= grant[r];
                if (core_rsp_valid[r] && core_rsp_ready[r]) begin
                    rr_ptr[r] <= (grant[r] == MAX_BANK_BITS'(NUM_BANKS - 1))
                        ? '0 : grant[r] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- cache_top.sv
// --------------------------------------
// Write-through, no write allocate; one miss in flight per bank
// NUM_BANKS a power of two, NUM_REQS and NUM_BANKS at most 2
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cache_top import cache_pkg::*; #(
    parameter int NUM_REQS  = 2,
    parameter int NUM_BANKS = 2,
    parameter int NUM_SETS  = 8
) (
    input  wire logic      clk,
    input  wire logic      reset,

    input  wire logic      core_req_valid [NUM_REQS],
    input  wire core_req_t core_req [NUM_REQS],
    output logic           core_req_ready [NUM_REQS],

    output logic           core_rsp_valid [NUM_REQS],
    output core_rsp_t      core_rsp [NUM_REQS],
    input  wire logic      core_rsp_ready [NUM_REQS],

    output logic           mem_req_valid,
    output mem_req_t       mem_req,
    input  wire logic      mem_req_ready,

    input  wire logic      mem_rsp_valid,
    input  wire mem_rsp_t  mem_rsp,
    output logic           mem_rsp_ready
);

    logic                  bank_req_valid [NUM_BANKS];
    bank_req_t             bank_req [NUM_BANKS];
    logic                  bank_req_ready [NUM_BANKS];

    logic                  bank_mem_req_valid [NUM_BANKS];
    mem_req_t              bank_mem_req [NUM_BANKS];
    logic                  bank_mem_req_ready [NUM_BANKS];
    logic                  bank_mem_rsp_valid [NUM_BANKS];
    logic [LINE_WIDTH-1:0] bank_mem_rsp_data;

    logic                  bank_rsp_valid [NUM_BANKS];
    bank_rsp_t             bank_rsp [NUM_BANKS];
    logic                  bank_rsp_ready [NUM_BANKS];

    req_dispatch #(
        .NUM_REQS  (NUM_REQS),
        .NUM_BANKS (NUM_BANKS)
    ) dispatch_inst (
        .clk            (clk),
        .reset          (reset),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .bank_req_valid (bank_req_valid),
        .bank_req       (bank_req),
        .bank_req_ready (bank_req_ready)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        cache_bank #(
            .NUM_BANKS (NUM_BANKS),
            .NUM_SETS  (NUM_SETS)
        ) bank_inst (
            .clk           (clk),
            .reset         (reset),
            .req_valid     (bank_req_valid[b]),
            .req           (bank_req[b]),
            .req_ready     (bank_req_ready[b]),
            .mem_req_valid (bank_mem_req_valid[b]),
            .mem_req       (bank_mem_req[b]),
            .mem_req_ready (bank_mem_req_ready[b]),
            .mem_rsp_valid (bank_mem_rsp_valid[b]),
            .mem_rsp_data  (bank_mem_rsp_data),
            .rsp_valid     (bank_rsp_valid[b]),
            .rsp           (bank_rsp[b]),
            .rsp_ready     (bank_rsp_ready[b])
        );
    end

    mem_arbiter #(
        .NUM_BANKS (NUM_BANKS)
    ) arbiter_inst (
        .clk                (clk),
        .reset              (reset),
        .bank_mem_req_valid (bank_mem_req_valid),
        .bank_mem_req       (bank_mem_req),
        .bank_mem_req_ready (bank_mem_req_ready),
        .mem_req_valid      (mem_req_valid),
        .mem_req            (mem_req),
        .mem_req_ready      (mem_req_ready),
        .mem_rsp_valid      (mem_rsp_valid),
        .mem_rsp            (mem_rsp),
        .mem_rsp_ready      (mem_rsp_ready),
        .bank_mem_rsp_valid (bank_mem_rsp_valid),
        .bank_mem_rsp_data  (bank_mem_rsp_data)
    );

    rsp_gather #(
        .NUM_REQS  (NUM_REQS),
        .NUM_BANKS (NUM_BANKS)
    ) gather_inst (
        .clk            (clk),
        .reset          (reset),
        .bank_rsp_valid (bank_rsp_valid),
        .bank_rsp       (bank_rsp),
        .bank_rsp_ready (bank_rsp_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready)
    );

endmodule

`default_nettype wire

//--- cache_assertions.sv
// --------------------------------------
// Bound into cache_top; checks the top-level streams
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cache_assertions import cache_pkg::*; #(
    parameter int NUM_REQS = 2
) (
    input wire logic      clk,
    input wire logic      reset,
    input wire logic      core_rsp_valid [NUM_REQS],
    input wire core_rsp_t core_rsp [NUM_REQS],
    input wire logic      core_rsp_ready [NUM_REQS],
    input wire logic      mem_req_valid,
    input wire mem_req_t  mem_req,
    input wire logic      mem_req_ready
);

    for (genvar r = 0; r < NUM_REQS; r++) begin : g_req
        assert property (@(posedge clk) disable iff (reset)
            core_rsp_valid[r] && !core_rsp_ready[r]
            |=> core_rsp_valid[r] && $stable(core_rsp[r]))
            else $error("core_rsp[%0d] changed before its transfer", r);
        assert property (@(posedge clk) reset |=> !core_rsp_valid[r])
            else $error("core_rsp_valid[%0d] high during reset", r);
    end

    assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("mem_req changed before its transfer");
    assert property (@(posedge clk) reset |=> !mem_req_valid)
        else $error("mem_req_valid high during reset");
    assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && mem_req.op == OP_WRITE |-> mem_req.word_en != '0)
        else $error("memory write with no word enabled");

endmodule

bind cache_top cache_assertions #(
    .NUM_REQS (NUM_REQS)
) assertions_inst (
    .clk            (clk),
    .reset          (reset),
    .core_rsp_valid (core_rsp_valid),
    .core_rsp       (core_rsp),
    .core_rsp_ready (core_rsp_ready),
    .mem_req_valid  (mem_req_valid),
    .mem_req        (mem_req),
    .mem_req_ready  (mem_req_ready)
);

`default_nettype wire

//--- tb_cache.sv
// --------------------------------------
// Random two-port traffic over words 0..63; memory answers in order
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_cache import cache_pkg::*; ();

    localparam int NUM_REQS = 2;
    localparam int NUM_BANKS = 2;
    localparam int NUM_SETS = 8;
    localparam int NUM_TX = 300;
    localparam int READ_TIMEOUT = 400;
    localparam int END_TIMEOUT = 20000;
    // Word bit, one bank bit, three set bits, then the line tag
    localparam int LTAG_LSB = 5;

    typedef struct packed {
        mem_op_e               op;
        logic [ADDR_WIDTH-2:0] line_addr;
        logic                  word;
        logic [WORD_WIDTH-1:0] data;
    } exp_mem_t;

    logic      clk = 1'b0;
    logic      reset = 1'b1;
    logic      core_req_valid [NUM_REQS] = '{default: 1'b0};
    core_req_t core_req [NUM_REQS] = '{default: '0};
    logic      core_req_ready [NUM_REQS];
    logic      core_rsp_valid [NUM_REQS];
    core_rsp_t core_rsp [NUM_REQS];
    logic      core_rsp_ready [NUM_REQS] = '{default: 1'b0};
    logic      mem_req_valid;
    mem_req_t  mem_req;
    logic      mem_req_ready = 1'b0;
    logic      mem_rsp_valid = 1'b0;
    mem_rsp_t  mem_rsp = '0;
    logic      mem_rsp_ready;

    logic [31:0]               lfsr_state = 32'h61ace28b;
    logic [WORD_WIDTH-1:0]     mem_words [1 << ADDR_WIDTH];
    logic [WORD_WIDTH-1:0]     model_words [1 << ADDR_WIDTH];
    logic                      mirror_valid [NUM_BANKS][NUM_SETS];
    logic [ADDR_WIDTH-LTAG_LSB-1:0] mirror_tag [NUM_BANKS][NUM_SETS];
    logic                      pend_valid [NUM_REQS][1 << TAG_WIDTH];
    logic [WORD_WIDTH-1:0]     pend_data [NUM_REQS][1 << TAG_WIDTH];
    int                        pend_age [NUM_REQS][1 << TAG_WIDTH];
    exp_mem_t                  exp_q [NUM_BANKS][$];
    mem_rsp_t                  rsp_q [$];
    int rsp_delay;
    int launched [NUM_REQS];
    int data_errs;
    int proto_errs;
    int timeout_errs;
    int exp_misses;
    int mem_reads;
    int both_reads;

    cache_top #(
        .NUM_REQS  (NUM_REQS),
        .NUM_BANKS (NUM_BANKS),
        .NUM_SETS  (NUM_SETS)
    ) cache_top_inst (
        .clk            (clk),
        .reset          (reset),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp        (mem_rsp),
        .mem_rsp_ready  (mem_rsp_ready)
    );

    always #20 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[31]};
        end
        return v;
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        data_errs++;
        $display("ERR %0t %s got %0h exp %0h", $time, name, got, exp);
    endtask

    task automatic init_models();
        for (int a = 0; a < (1 << ADDR_WIDTH); a++) begin
            mem_words[a] = 32'hA5000000 + 32'(a);
            model_words[a] = 32'hA5000000 + 32'(a);
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            exp_q[b].delete();
            for (int s = 0; s < NUM_SETS; s++) begin
                mirror_valid[b][s] = 1'b0;
                mirror_tag[b][s] = '0;
            end
        end
        for (int r = 0; r < NUM_REQS; r++) begin
            launched[r] = 0;
            for (int t = 0; t < (1 << TAG_WIDTH); t++) begin
                pend_valid[r][t] = 1'b0;
                pend_age[r][t] = 0;
            end
        end
        rsp_q.delete();
        rsp_delay = 0;
        data_errs = 0;
        proto_errs = 0;
        timeout_errs = 0;
        exp_misses = 0;
        mem_reads = 0;
        both_reads = 0;
    endtask

    task automatic check_responses();
        logic [TAG_WIDTH-1:0] t;
        for (int r = 0; r < NUM_REQS; r++) begin
            if (core_rsp_valid[r] && core_rsp_ready[r]) begin
                t = core_rsp[r].tag;
                if (!pend_valid[r][t]) begin
                    proto_errs++;
                    $display("%0t: requester %0d got tag %0d with no read outstanding",
                        $time, r, t);
                end else begin
                    if (core_rsp[r].data !== pend_data[r][t]) begin
                        report_value($sformatf("core_rsp[%0d].data", r),
                            core_rsp[r].data, pend_data[r][t]);
                    end
                    pend_valid[r][t] = 1'b0;
                end
            end
            for (int k = 0; k < (1 << TAG_WIDTH); k++) begin
                if (pend_valid[r][k]) begin
                    pend_age[r][k]++;
                    if (pend_age[r][k] > READ_TIMEOUT) begin
                        timeout_errs++;
                        pend_valid[r][k] = 1'b0;
                        $display("%0t: read tag %0d on requester %0d was never answered",
                            $time, k, r);
                    end
                end
            end
        end
    endtask

    task automatic track_requests();
        core_req_t q;
        logic bank;
        logic [2:0] set;
        logic [ADDR_WIDTH-LTAG_LSB-1:0] ltag;
        int reads;
        reads = 0;
        for (int r = 0; r < NUM_REQS; r++) begin
            if (core_req_valid[r] && core_req_ready[r]) begin
                q = core_req[r];
                bank = q.addr[1];
                set = q.addr[4:2];
                ltag = q.addr[ADDR_WIDTH-1:LTAG_LSB];
                if (q.op == OP_WRITE) begin
                    model_words[q.addr] = q.data;
                    exp_q[bank].push_back('{OP_WRITE, q.addr[ADDR_WIDTH-1:1], q.addr[0], q.data});
                end else begin
                    reads++;
                    pend_valid[r][q.tag] = 1'b1;
                    pend_data[r][q.tag] = model_words[q.addr];
                    pend_age[r][q.tag] = 0;
                    // Write misses never allocate, so only reads fill the mirror
                    if (!(mirror_valid[bank][set] && mirror_tag[bank][set] == ltag)) begin
                        exp_misses++;
                        mirror_valid[bank][set] = 1'b1;
                        mirror_tag[bank][set] = ltag;
                        exp_q[bank].push_back('{OP_READ, q.addr[ADDR_WIDTH-1:1], q.addr[0], '0});
                    end
                end
            end
        end
        if (reads == NUM_REQS) begin
            both_reads++;
        end
    endtask

    task automatic serve_memory();
        exp_mem_t e;
        mem_rsp_t rsp;
        logic bank;
        if (mem_req_valid && mem_req_ready) begin
            bank = mem_req.tag;
            if (exp_q[bank].size() == 0) begin
                proto_errs++;
                $display("%0t: unexpected memory request from bank %0d", $time, bank);
            end else begin
                e = exp_q[bank].pop_front();
                if (mem_req.op != e.op) begin
                    report_value("mem_req.op", 32'(mem_req.op), 32'(e.op));
                end else if (mem_req.line_addr !== e.line_addr) begin
                    report_value("mem_req.line_addr", 32'(mem_req.line_addr), 32'(e.line_addr));
                end else if (e.op == OP_WRITE) begin
                    if (mem_req.word_en !== (2'b01 << e.word)) begin
                        report_value("mem_req.word_en", 32'(mem_req.word_en),
                            32'(2'b01 << e.word));
                    end
                    if (mem_req.data[e.word * WORD_WIDTH +: WORD_WIDTH] !== e.data) begin
                        report_value("mem_req.data",
                            mem_req.data[e.word * WORD_WIDTH +: WORD_WIDTH], e.data);
                    end
                end
            end
            if (mem_req.op == OP_WRITE) begin
                for (int w = 0; w < LINE_WORDS; w++) begin
                    if (mem_req.word_en[w]) begin
                        mem_words[{mem_req.line_addr, w[0]}] = mem_req.data[w * WORD_WIDTH +: WORD_WIDTH];
                    end
                end
            end else begin
                mem_reads++;
                rsp.data = {mem_words[{mem_req.line_addr, 1'b1}],
                            mem_words[{mem_req.line_addr, 1'b0}]};
                rsp.tag = mem_req.tag;
                rsp_q.push_back(rsp);
            end
        end
        // Responses leave in order, each after a short random gap
        if (!(mem_rsp_valid && !mem_rsp_ready)) begin
            if (rsp_q.size() > 0 && rsp_delay == 0) begin
                mem_rsp_valid <= 1'b1;
                mem_rsp <= rsp_q.pop_front();
                rsp_delay = int'(random_bits(2));
            end else begin
                mem_rsp_valid <= 1'b0;
                if (rsp_delay > 0) begin
                    rsp_delay--;
                end
            end
        end
    endtask

    task automatic drive_requests();
        core_req_t q;
        for (int r = 0; r < NUM_REQS; r++) begin
            if (!(core_req_valid[r] && !core_req_ready[r])) begin
                q.addr = ADDR_WIDTH'(random_bits(6));
                q.op = (random_bits(2) == 0) ? OP_WRITE : OP_READ;
                q.data = random_bits(32);
                q.tag = TAG_WIDTH'(random_bits(6));
                // First pair reads both banks in the same cycle
                if (launched[r] == 0) begin
                    q.addr = ADDR_WIDTH'(r * 2);
                    q.op = OP_READ;
                end
                if (launched[r] < NUM_TX && random_bits(2) != 0
                        && !(q.op == OP_READ && pend_valid[r][q.tag])) begin
                    core_req_valid[r] <= 1'b1;
                    core_req[r] <= q;
                    launched[r]++;
                end else begin
                    core_req_valid[r] <= 1'b0;
                end
            end
        end
    endtask

    function automatic logic traffic_drained();
        logic idle;
        idle = rsp_q.size() == 0 && !mem_rsp_valid;
        for (int r = 0; r < NUM_REQS; r++) begin
            idle = idle && launched[r] == NUM_TX && !core_req_valid[r];
            for (int t = 0; t < (1 << TAG_WIDTH); t++) begin
                idle = idle && !pend_valid[r][t];
            end
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            idle = idle && exp_q[b].size() == 0;
        end
        return idle;
    endfunction

    task automatic finish_run(input int end_errs);
        int total;
        total = data_errs + proto_errs + timeout_errs + end_errs;
        $display("errors %0d: data %0d, protocol %0d, timeout %0d, end %0d",
            total, data_errs, proto_errs, timeout_errs, end_errs);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            init_models();
        end else begin
            check_responses();
            track_requests();
            serve_memory();
            drive_requests();
            for (int r = 0; r < NUM_REQS; r++) begin
                core_rsp_ready[r] <= (random_bits(2) != 0);
            end
            mem_req_ready <= (random_bits(1) != 0);
        end
    end

    initial begin
        int cycles;
        int end_errs;
        end_errs = 0;
        cycles = 0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        while (!traffic_drained() && cycles < END_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!traffic_drained()) begin
            end_errs++;
            $display("%0t: traffic did not drain within %0d cycles", $time, END_TIMEOUT);
        end
        if (mem_reads != exp_misses) begin
            end_errs++;
            $display("ERR %0t mem_req reads got %0d exp %0d", $time, mem_reads, exp_misses);
        end
        if (both_reads == 0) begin
            end_errs++;
            $display("No cycle accepted reads from both requesters together");
        end
        finish_run(end_errs);
    end

endmodule

`default_nettype wire

//--- vlog.f
cache_pkg.sv
req_dispatch.sv
cache_bank.sv
mem_arbiter.sv
rsp_gather.sv
cache_top.sv
cache_assertions.sv
tb_cache.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Mdir obj_dir
TOP       = tb_cache
FILELIST  = vlog.f
LOG       = sim.log
FAIL_MSG  = Done: errors found

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
